//--- aud_ctrl.sv
`timescale 1ns/10ps

module aud_ctrl import aud_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_start,
    input  logic            i_pause,
    input  logic            i_stop,
    input  logic            i_play,
    input  logic            i_full,
    input  logic [ADDR_W:0] i_count,
    input  logic            i_end,
    output logic            o_rec_en,
    output logic            o_rec_clear,
    output logic            o_play_en,
    output logic            o_play_start,
    output logic [ADDR_W:0] o_rec_len,
    output logic            o_finish,
    output logic            o_done
);

aud_mode_e       state_r, state_w;
logic [ADDR_W:0] rec_len_r, rec_len_w;
logic            finish_r, finish_w;
logic            done_r, done_w;
logic            start_ok;
logic            play_ok;

assign start_ok = (state_r == M_IDLE) && i_start;
assign play_ok  = (state_r == M_IDLE) && i_play && !i_start;  // Start wins a tie

assign o_rec_clear  = start_ok;
assign o_play_start = play_ok;
assign o_rec_en     = (state_r == M_REC);
assign o_play_en    = (state_r == M_PLAY);
assign o_rec_len    = rec_len_r;
assign o_finish     = finish_r;
assign o_done       = done_r;

always_comb begin
    state_w   = state_r;
    rec_len_w = rec_len_r;
    finish_w  = 1'b0;
    done_w    = 1'b0;
    case (state_r)
        M_IDLE: begin
            if (start_ok) begin
                state_w = M_REC;
            end
            else if (play_ok) begin
                state_w = M_PLAY;
            end
        end
        M_REC, M_PAUSE: begin
            if (i_stop || i_full) begin
                state_w   = M_IDLE;
                rec_len_w = i_count;    // Count already holds a write in this cycle
                finish_w  = 1'b1;
            end
            else if (i_pause) begin
                state_w = (state_r == M_REC) ? M_PAUSE : M_REC;
            end
        end
        M_PLAY: begin
            if (i_end) begin
                state_w = M_IDLE;
                done_w  = 1'b1;
            end
        end
        default: state_w = M_IDLE;
    endcase
end

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        state_r   <= M_IDLE;
        rec_len_r <= '0;
        finish_r  <= 1'b0;
        done_r    <= 1'b0;
    end
    else begin
        state_r   <= state_w;
        rec_len_r <= rec_len_w;
        finish_r  <= finish_w;
        done_r    <= done_w;
    end
end

// The SRAM port is shared, so recorder and player must never run together
a_one_owner: assert property (@(posedge i_clk) disable iff (i_rst_n)
    !(o_rec_en && o_play_en));

endmodule

//--- aud_pkg.sv
package aud_pkg;

// ************************************************************
// Sample and buffer sizes
// ************************************************************
localparam int DATA_W    = 16;              // Bits per left-channel sample
localparam int ADDR_W    = 6;
localparam int REC_WORDS = 64;              // Recording stops here
localparam int BIT_W     = $clog2(DATA_W);  // Bit counter inside one frame

localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(DATA_W - 1);
localparam logic [ADDR_W:0]  CNT_FULL = (ADDR_W + 1)'(REC_WORDS);

// ************************************************************
// Controller modes
// ************************************************************
typedef enum logic [1:0] {
    M_IDLE  = 2'd0,
    M_REC   = 2'd1,
    M_PAUSE = 2'd2,   // Recording held, buffer keeps its contents
    M_PLAY  = 2'd3
} aud_mode_e;

// One access on the single SRAM port, read data comes back combinationally
typedef struct packed {
    logic              we;
    logic              re;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
} sram_req_t;

endpackage

//--- aud_player.sv
`timescale 1ns/10ps

module aud_player import aud_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_lrc,
    input  logic              i_play_en,
    input  logic              i_play_start,
    input  logic [ADDR_W:0]   i_play_len,
    input  logic [DATA_W-1:0] i_rdata,
    output sram_req_t         o_req,
    output logic              o_dacdat,
    output logic              o_end
);

logic              lrc_r;
logic              re_r, re_w;
logic              end_r, end_w;
logic              loaded_r, loaded_w;
logic              sh_active_r, sh_active_w;
logic [BIT_W-1:0]  sh_cnt_r, sh_cnt_w;
logic [DATA_W-1:0] data_r, data_w;
logic [ADDR_W:0]   rd_cnt_r, rd_cnt_w;
logic              lrc_rise;
logic              lrc_fall;
logic              shift_go;

assign lrc_rise = !lrc_r && i_lrc;
assign lrc_fall = lrc_r && !i_lrc;

// The MSB must show in the very first low cycle, hence the edge term
assign shift_go = sh_active_r || (lrc_fall && loaded_r);
assign o_dacdat = shift_go ? data_r[DATA_W-1] : 1'b0;
assign o_end    = end_r;

assign o_req.we    = 1'b0;
assign o_req.re    = re_r;
assign o_req.addr  = rd_cnt_r[ADDR_W-1:0];
assign o_req.wdata = '0;

always_comb begin
    re_w        = 1'b0;
    end_w       = 1'b0;
    loaded_w    = loaded_r;
    sh_active_w = sh_active_r;
    sh_cnt_w    = sh_cnt_r;
    data_w      = data_r;
    rd_cnt_w    = rd_cnt_r;
    if (i_play_start) begin
        loaded_w    = 1'b0;
        sh_active_w = 1'b0;
        sh_cnt_w    = '0;
        rd_cnt_w    = '0;
    end
    else begin
        if (lrc_rise && i_play_en) begin
            if (rd_cnt_r == i_play_len) begin
                end_w = 1'b1;   // Every stored word has been sent
            end
            else begin
                re_w = 1'b1;
            end
        end
        if (re_r) begin
            data_w   = i_rdata;
            loaded_w = 1'b1;
            rd_cnt_w = rd_cnt_r + 1'b1;
        end
        if (shift_go) begin
            data_w      = {data_r[DATA_W-2:0], 1'b0};
            loaded_w    = 1'b0;
            sh_cnt_w    = sh_cnt_r + 1'b1;
            sh_active_w = (sh_cnt_r != BIT_LAST);
        end
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        lrc_r       <= 1'b0;
        re_r        <= 1'b0;
        end_r       <= 1'b0;
        loaded_r    <= 1'b0;
        sh_active_r <= 1'b0;
        sh_cnt_r    <= '0;
        rd_cnt_r    <= '0;
    end
    else begin
        lrc_r       <= i_lrc;
        re_r        <= re_w;
        end_r       <= end_w;
        loaded_r    <= loaded_w;
        sh_active_r <= sh_active_w;
        sh_cnt_r    <= sh_cnt_w;
        rd_cnt_r    <= rd_cnt_w;
    end
end

always_ff @(posedge i_clk) begin
    data_r <= data_w;
end

a_read_in_range: assert property (@(posedge i_clk) disable iff (i_rst_n)
    o_req.re |-> (rd_cnt_r < i_play_len));

endmodule

//--- aud_recorder.sv
`timescale 1ns/10ps

module aud_recorder import aud_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_lrc,
    input  logic            i_adcdat,
    input  logic            i_rec_en,
    input  logic            i_rec_clear,
    output sram_req_t       o_req,
    output logic            o_full,
    output logic [ADDR_W:0] o_count
);

logic              lrc_r;
logic              active_r, active_w;
logic [BIT_W-1:0]  bit_cnt_r, bit_cnt_w;
logic              pend_r, pend_w;
logic [DATA_W-1:0] data_r, data_w;
logic [ADDR_W:0]   count_r, count_w;
logic              lrc_fall;
logic              we;

assign lrc_fall = lrc_r && !i_lrc;      // First cycle of the left half
assign o_full   = (count_r == CNT_FULL);

// The word goes out only if recording is still enabled in its write cycle
assign we = pend_r && i_rec_en;

assign o_req.we    = we;
assign o_req.re    = 1'b0;
assign o_req.addr  = count_r[ADDR_W-1:0];
assign o_req.wdata = data_r;

// Includes the word being written, so a stop in the write cycle keeps it
assign o_count = count_r + {{ADDR_W{1'b0}}, we};

// ************************************************************
// Capture of one left-channel word per frame
// ************************************************************
always_comb begin
    active_w  = active_r;
    bit_cnt_w = bit_cnt_r;
    pend_w    = 1'b0;
    data_w    = data_r;
    count_w   = count_r;
    if (active_r) begin
        if (!i_rec_en || i_lrc) begin
            active_w = 1'b0;    // Partial frame is dropped
        end
        else begin
            data_w    = {data_r[DATA_W-2:0], i_adcdat};
            bit_cnt_w = bit_cnt_r + 1'b1;
            if (bit_cnt_r == BIT_LAST) begin
                active_w = 1'b0;
                pend_w   = 1'b1;
            end
        end
    end
    else if (lrc_fall && i_rec_en && !o_full) begin
        active_w  = 1'b1;
        bit_cnt_w = BIT_W'(1);
        data_w    = {data_r[DATA_W-2:0], i_adcdat};   // Bit 0 sits in the edge cycle
    end

    if (we) begin
        count_w = count_r + 1'b1;
    end
    if (i_rec_clear) begin
        count_w = '0;
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        lrc_r     <= 1'b0;
        active_r  <= 1'b0;
        bit_cnt_r <= '0;
        pend_r    <= 1'b0;
        count_r   <= '0;
    end
    else begin
        lrc_r     <= i_lrc;
        active_r  <= active_w;
        bit_cnt_r <= bit_cnt_w;
        pend_r    <= pend_w;
        count_r   <= count_w;
    end
end

always_ff @(posedge i_clk) begin
    data_r <= data_w;
end

// Once the buffer is full no later frame may reach the SRAM
a_no_write_full: assert property (@(posedge i_clk) disable iff (i_rst_n)
    o_full |-> !o_req.we);

endmodule

//--- aud_top.sv
`timescale 1ns/10ps

module aud_top import aud_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_lrc,
    input  logic              i_adcdat,
    input  logic              i_start,
    input  logic              i_pause,
    input  logic              i_stop,
    input  logic              i_play,
    input  logic [DATA_W-1:0] i_sram_rdata,
    output sram_req_t         o_sram,
    output logic              o_dacdat,
    output logic [ADDR_W:0]   o_rec_len,
    output logic              o_finish,
    output logic              o_done
);

logic            rec_en;
logic            rec_clear;
logic            play_en;
logic            play_start;
logic            rec_full;
logic [ADDR_W:0] rec_count;
logic [ADDR_W:0] rec_len;
logic            play_end;
sram_req_t       rec_req;
sram_req_t       play_req;

assign o_rec_len = rec_len;

// ************************************************************
// Single SRAM port, owned by the recorder while it is enabled
// ************************************************************
assign o_sram = rec_en ? rec_req : play_req;

aud_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_start      (i_start),
    .i_pause      (i_pause),
    .i_stop       (i_stop),
    .i_play       (i_play),
    .i_full       (rec_full),
    .i_count      (rec_count),
    .i_end        (play_end),
    .o_rec_en     (rec_en),
    .o_rec_clear  (rec_clear),
    .o_play_en    (play_en),
    .o_play_start (play_start),
    .o_rec_len    (rec_len),
    .o_finish     (o_finish),
    .o_done       (o_done)
);

aud_recorder u_recorder (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_lrc       (i_lrc),
    .i_adcdat    (i_adcdat),
    .i_rec_en    (rec_en),
    .i_rec_clear (rec_clear),
    .o_req       (rec_req),
    .o_full      (rec_full),
    .o_count     (rec_count)
);

aud_player u_player (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_lrc        (i_lrc),
    .i_play_en    (play_en),
    .i_play_start (play_start),
    .i_play_len   (rec_len),
    .i_rdata      (i_sram_rdata),
    .o_req        (play_req),
    .o_dacdat     (o_dacdat),
    .o_end        (play_end)
);

endmodule

//--- build.f
aud_pkg.sv
aud_recorder.sv
aud_player.sv
aud_ctrl.sv
aud_top.sv
tb_aud_top.sv

//--- tb_aud_top.sv
`timescale 1ns/10ps

module tb_aud_top import aud_pkg::*; ();

localparam int HALF  = 20;          // Bit clocks per LRC half
localparam int FRAME = 2 * HALF;

localparam logic [3:0] K_START = 4'b1000;
localparam logic [3:0] K_PAUSE = 4'b0100;
localparam logic [3:0] K_STOP  = 4'b0010;
localparam logic [3:0] K_PLAY  = 4'b0001;

typedef struct packed {
    int                cyc;         // Cycle that carries bit 0 of the word
    logic [DATA_W-1:0] word;
} sent_t;

typedef struct packed {
    int        cyc;
    logic [3:0] keys;
} key_t;

logic              clk;
logic              i_rst_n;
logic              i_lrc;
logic              i_adcdat;
logic              i_start;
logic              i_pause;
logic              i_stop;
logic              i_play;
logic [DATA_W-1:0] i_sram_rdata;
sram_req_t         o_sram;
logic              o_dacdat;
logic [ADDR_W:0]   o_rec_len;
logic              o_finish;
logic              o_done;

logic [DATA_W-1:0] mem [REC_WORDS];
logic [DATA_W-1:0] tx_word;
logic [DATA_W-1:0] exp_words [$];
sent_t             sent_q [$];
key_t              key_q [$];
int                cyc;
int                phase;           // 0 to HALF-1 is the left half
int                wr_cnt;
int                rd_cnt;
int                fin_cnt;
int                done_cnt;
int                val_errs;
int                misc_errs;
int                timeouts;

aud_top DUT (
    .i_clk        (clk),
    .i_rst_n      (i_rst_n),
    .i_lrc        (i_lrc),
    .i_adcdat     (i_adcdat),
    .i_start      (i_start),
    .i_pause      (i_pause),
    .i_stop       (i_stop),
    .i_play       (i_play),
    .i_sram_rdata (i_sram_rdata),
    .o_sram       (o_sram),
    .o_dacdat     (o_dacdat),
    .o_rec_len    (o_rec_len),
    .o_finish     (o_finish),
    .o_done       (o_done)
);

always #20 clk = ~clk;

// ************************************************************
// LRC, ADC serializer and SRAM model
// ************************************************************
always @(posedge clk) begin
    int    nxt;
    sent_t s;
    nxt = (phase == FRAME - 1) ? 0 : phase + 1;
    if (nxt == 0) begin
        tx_word = DATA_W'($urandom());
        s.cyc   = cyc + 1;
        s.word  = tx_word;
        sent_q.push_back(s);
    end
    phase    <= nxt;
    i_lrc    <= (nxt >= HALF);
    i_adcdat <= (nxt < DATA_W) ? tx_word[DATA_W - 1 - nxt] : 1'b0;   // MSB first
    cyc      <= cyc + 1;
end

assign i_sram_rdata = mem[o_sram.addr];

always @(negedge clk) begin
    if (o_sram.we === 1'b1) begin
        mem[o_sram.addr] <= o_sram.wdata;
    end
end

// Strobe counters see the values of the cycle that just ended
always @(posedge clk) begin
    if (i_rst_n === 1'b0) begin
        wr_cnt   <= wr_cnt + (o_sram.we === 1'b1);
        rd_cnt   <= rd_cnt + (o_sram.re === 1'b1);
        fin_cnt  <= fin_cnt + (o_finish === 1'b1);
        done_cnt <= done_cnt + (o_done === 1'b1);
    end
end

// ************************************************************
// Reference model and compare tasks
// ************************************************************
function automatic int ref_record(input int first_cyc, input int last_cyc);
    int                st;   // 0 idle, 1 recording, 2 paused
    int                count;
    int                si;
    int                ki;
    int                cand_cyc;
    bit                cand;
    bit                en;
    bit                full;
    logic [3:0]        k;
    logic [DATA_W-1:0] cand_word;
    exp_words.delete();
    st = 0;
    count = 0;
    si = 0;
    ki = 0;
    cand = 1'b0;
    cand_cyc = 0;
    cand_word = '0;
    for (int c = first_cyc; c <= last_cyc; c++) begin
        en   = (st == 1);
        full = (count == REC_WORDS);
        while (si < sent_q.size() && sent_q[si].cyc < c) begin
            si++;
        end
        if (si < sent_q.size() && sent_q[si].cyc == c) begin
            cand      = en && !full;    // A frame counts only if enabled from its first bit
            cand_cyc  = c;
            cand_word = sent_q[si].word;
        end
        if (!en) begin
            cand = 1'b0;
        end
        if (cand && c == cand_cyc + DATA_W) begin
            exp_words.push_back(cand_word);
            count++;
            cand = 1'b0;
        end
        k = '0;
        while (ki < key_q.size() && key_q[ki].cyc < c) begin
            ki++;
        end
        if (ki < key_q.size() && key_q[ki].cyc == c) begin
            k = key_q[ki].keys;
        end
        if (st == 0) begin
            st = (k & K_START) != 0 ? 1 : 0;
        end
        else if ((k & K_STOP) != 0 || full) begin
            return count;
        end
        else if ((k & K_PAUSE) != 0) begin
            st = (st == 1) ? 2 : 1;
        end
    end
    return -1;
endfunction

task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
        $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        val_errs++;
    end
endtask

task automatic check_count(input string name, input logic [ADDR_W:0] got,
                           input logic [ADDR_W:0] exp);
    if (got !== exp) begin
        $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
        val_errs++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        val_errs++;
    end
endtask

// ************************************************************
// Stimulus
// ************************************************************
task automatic press_key(input logic [3:0] keys);
    key_t k;
    @(posedge clk);
    {i_start, i_pause, i_stop, i_play} <= keys;
    k.cyc  = cyc + 1;
    k.keys = keys;
    key_q.push_back(k);
    @(posedge clk);
    {i_start, i_pause, i_stop, i_play} <= 4'b0000;
endtask

task automatic wait_finish(input int limit, output bit ok);
    int guard;
    guard = 0;
    ok = 1'b1;
    @(negedge clk);
    while (o_finish !== 1'b1) begin
        guard++;
        if (guard > limit) begin
            $display("Timeout at %0t: o_finish did not pulse within %0d cycles", $time, limit);
            timeouts++;
            ok = 1'b0;
            return;
        end
        @(negedge clk);
    end
endtask

task automatic record_and_check(input int run_a, input int held, input int run_b,
                                input bit use_stop, output int len, output bit ok);
    int start_cyc;
    int wr0;
    int rd0;
    int fin0;
    wr0 = wr_cnt;
    rd0 = rd_cnt;
    fin0 = fin_cnt;
    len = 0;
    press_key(K_START);
    start_cyc = key_q[key_q.size() - 1].cyc;
    repeat (FRAME) @(posedge clk);
    press_key(K_PLAY);                  // Must not interrupt the recording
    repeat (run_a * FRAME) @(posedge clk);
    if (held > 0) begin
        press_key(K_PAUSE);
        repeat (held * FRAME) @(posedge clk);
        press_key(K_PAUSE);
        repeat (run_b * FRAME) @(posedge clk);
    end
    if (use_stop) begin
        press_key(K_STOP);
    end
    wait_finish(2 * REC_WORDS * FRAME, ok);
    if (!ok) begin
        return;
    end
    len = ref_record(start_cyc, cyc);
    if (len < 0) begin
        $display("Reference model saw no end of the recording started in cycle %0d", start_cyc);
        misc_errs++;
        ok = 1'b0;
        return;
    end
    check_count("o_rec_len", o_rec_len, (ADDR_W + 1)'(len));
    if (!use_stop) begin
        check_count("o_rec_len", o_rec_len, (ADDR_W + 1)'(REC_WORDS));
    end
    for (int a = 0; a < len; a++) begin
        check_word($sformatf("sram[%0d]", a), mem[a], exp_words[a]);
    end
    repeat (2 * FRAME) @(negedge clk);  // Long enough for a stray write to show up
    check_count("SRAM writes", (ADDR_W + 1)'(wr_cnt - wr0), (ADDR_W + 1)'(len));
    check_count("SRAM reads", (ADDR_W + 1)'(rd_cnt - rd0), '0);
    check_count("o_finish pulses", (ADDR_W + 1)'(fin_cnt - fin0), (ADDR_W + 1)'(1));
endtask

task automatic check_playback(input int len, output bit ok);
    int   guard;
    int   j;
    int   tail;
    int   done0;
    bit   seen_done;
    logic exp_bit;
    ok = 1'b1;
    guard = 0;
    j = -1;
    tail = 0;
    seen_done = 1'b0;
    done0 = done_cnt;
    press_key(K_PLAY);
    @(negedge clk);
    while (phase != HALF) begin         // First rising LRC edge in play mode
        guard++;
        if (guard > 2 * FRAME) begin
            $display("Timeout at %0t: LRC never went high after play", $time);
            timeouts++;
            ok = 1'b0;
            return;
        end
        @(negedge clk);
    end
    guard = 0;
    while (tail < FRAME) begin
        @(negedge clk);
        guard++;
        if (guard > (len + 3) * FRAME) begin
            $display("Timeout at %0t: o_done did not pulse after %0d words", $time, len);
            timeouts++;
            ok = 1'b0;
            return;
        end
        if (phase == 0) begin
            j++;
        end
        exp_bit = 1'b0;
        if (j >= 0 && j < len && phase < DATA_W) begin
            exp_bit = exp_words[j][DATA_W - 1 - phase];
        end
        check_bit("o_dacdat", o_dacdat, exp_bit);
        if (o_done === 1'b1) begin
            if (seen_done || j != len - 1 || phase < DATA_W) begin
                $display("o_done pulsed at %0t before the last word ended or twice", $time);
                misc_errs++;
            end
            seen_done = 1'b1;
        end
        if (seen_done) begin
            tail++;
        end
    end
    check_count("o_done pulses", (ADDR_W + 1)'(done_cnt - done0), (ADDR_W + 1)'(1));
endtask

task automatic run_all();
    int len;
    bit ok;
    @(negedge clk);
    check_bit("o_finish", o_finish, 1'b0);
    check_bit("o_done", o_done, 1'b0);
    check_bit("o_sram.we", o_sram.we, 1'b0);
    check_bit("o_sram.re", o_sram.re, 1'b0);
    check_bit("o_dacdat", o_dacdat, 1'b0);
    check_count("o_rec_len", o_rec_len, '0);
    press_key(K_PAUSE);
    press_key(K_STOP);
    repeat (2 * FRAME) @(negedge clk);
    check_count("SRAM writes", (ADDR_W + 1)'(wr_cnt), '0);
    check_count("o_finish pulses", (ADDR_W + 1)'(fin_cnt), '0);
    check_count("o_rec_len", o_rec_len, '0);
    record_and_check(10, 0, 0, 1'b1, len, ok);
    if (!ok) begin
        return;
    end
    record_and_check(3, 4, 3, 1'b1, len, ok);
    if (!ok) begin
        return;
    end
    record_and_check(2, 0, 0, 1'b0, len, ok);   // Runs until the buffer is full
    if (!ok) begin
        return;
    end
    check_playback(len, ok);
endtask

initial begin
    void'($urandom(82884));
    clk = 1'b0;
    i_rst_n = 1'b1;
    i_lrc = 1'b1;
    i_adcdat = 1'b0;
    i_start = 1'b0;
    i_pause = 1'b0;
    i_stop = 1'b0;
    i_play = 1'b0;
    tx_word = '0;
    cyc = 0;
    phase = FRAME - 1;
    wr_cnt = 0;
    rd_cnt = 0;
    fin_cnt = 0;
    done_cnt = 0;
    val_errs = 0;
    misc_errs = 0;
    timeouts = 0;
    for (int a = 0; a < REC_WORDS; a++) begin
        mem[a] = DATA_W'(16'hC3A5 ^ (a * 16'h0409));
    end
    repeat (10) @(posedge clk);
    i_rst_n <= 1'b0;
    run_all();
    $display("Errors: %0d value, %0d other, %0d timeouts", val_errs, misc_errs, timeouts);
    if (val_errs == 0 && misc_errs == 0 && timeouts == 0) begin
        $display("=== PASS ===");
    end
    else begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule
